// File: axi_burst_mem.f
hdl/axi_mem_pkg.sv
hdl/burst_tracker.sv
hdl/write_id_fifo.sv
hdl/word_memory.sv
hdl/read_beat_issuer.sv
hdl/write_beat_sink.sv
hdl/axi_burst_mem.sv
test/axi_burst_mem_props.sv
test/tb_axi_burst_mem.sv

// File: hdl/axi_burst_mem.sv
module axi_burst_mem (
    input  logic                               clk,
    input  logic                               reset,
    // write address
    input  logic [axi_mem_pkg::id_len-1:0]     awid,
    input  logic [axi_mem_pkg::addr_len-1:0]   awaddr,
    input  logic [7:0]                         awlen,
    input  logic [1:0]                         awburst,
    input  logic                               awvalid,
    output logic                               awready,
    // write data
    input  logic [axi_mem_pkg::data_width-1:0] wdata,
    input  logic [axi_mem_pkg::strb_width-1:0] wstrb,
    input  logic                               wlast,   // checked by the bound props only
    input  logic                               wvalid,
    output logic                               wready,
    // write response
    input  logic                               bready,
    output logic [axi_mem_pkg::id_len-1:0]     bid,
    output logic                               bvalid,
    // read address
    input  logic [axi_mem_pkg::id_len-1:0]     arid,
    input  logic [axi_mem_pkg::addr_len-1:0]   araddr,
    input  logic [7:0]                         arlen,
    input  logic [1:0]                         arburst,
    input  logic                               arvalid,
    output logic                               arready,
    // read data
    input  logic                               rready,
    output logic [axi_mem_pkg::id_len-1:0]     rid,
    output logic [axi_mem_pkg::data_width-1:0] rdata,
    output logic                               rlast,
    output logic                               rvalid
);

    logic [axi_mem_pkg::num_ids-1:0]       rd_busy, wr_busy;
    logic [axi_mem_pkg::addr_len-1:0]      rd_sel_addr, wr_sel_addr;
    logic                                  rd_sel_last, wr_sel_last;
    logic [axi_mem_pkg::id_len-1:0]        rd_sel_id;
    logic                                  rd_step, rd_release;
    logic                                  wr_step, wr_release;
    logic [axi_mem_pkg::id_len-1:0]        head_id;
    logic                                  head_valid, pop;
    logic [axi_mem_pkg::word_addr_len-1:0] rd_mem_addr, wr_mem_addr;
    logic [axi_mem_pkg::data_width-1:0]    rd_mem_data, wr_mem_data;
    logic [axi_mem_pkg::strb_width-1:0]    wr_mem_strb;
    logic                                  wr_mem_en;

    // accept only into a free slot of that id
    assign awready = awvalid && !wr_busy[awid];
    assign arready = arvalid && !rd_busy[arid];
    assign wready = 1'b1;

    burst_tracker u_rd_tracker (
        .clk(clk), .reset(reset),
        .start(arready), .start_id(arid), .start_addr(araddr), .start_len(arlen),
        .start_burst(axi_mem_pkg::burst_type_e'(arburst)),
        .step(rd_step), .release_slot(rd_release), .sel_id(rd_sel_id),
        .busy(rd_busy), .sel_addr(rd_sel_addr), .sel_last(rd_sel_last)
    );

    // write side always works on the oldest accepted id
    burst_tracker u_wr_tracker (
        .clk(clk), .reset(reset),
        .start(awready), .start_id(awid), .start_addr(awaddr), .start_len(awlen),
        .start_burst(axi_mem_pkg::burst_type_e'(awburst)),
        .step(wr_step), .release_slot(wr_release), .sel_id(head_id),
        .busy(wr_busy), .sel_addr(wr_sel_addr), .sel_last(wr_sel_last)
    );

    write_id_fifo u_write_id_fifo (
        .clk(clk), .reset(reset), .push(awready), .push_id(awid), .pop(pop),
        .head_id(head_id), .head_valid(head_valid)
    );

    word_memory u_word_memory (
        .clk(clk), .wr_en(wr_mem_en), .wr_addr(wr_mem_addr), .wr_data(wr_mem_data),
        .wr_strb(wr_mem_strb), .rd_addr(rd_mem_addr), .rd_data(rd_mem_data)
    );

    read_beat_issuer u_read_beat_issuer (
        .clk(clk), .reset(reset), .busy(rd_busy), .sel_addr(rd_sel_addr),
        .sel_last(rd_sel_last), .mem_data(rd_mem_data), .rready(rready),
        .sel_id(rd_sel_id), .step(rd_step), .release_slot(rd_release),
        .mem_addr(rd_mem_addr), .rid(rid), .rdata(rdata), .rlast(rlast), .rvalid(rvalid)
    );

    write_beat_sink u_write_beat_sink (
        .clk(clk), .reset(reset), .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid),
        .head_id(head_id), .head_valid(head_valid), .sel_addr(wr_sel_addr),
        .sel_last(wr_sel_last), .bready(bready),
        .step(wr_step), .release_slot(wr_release), .pop(pop),
        .mem_wr_en(wr_mem_en), .mem_wr_addr(wr_mem_addr), .mem_wr_data(wr_mem_data),
        .mem_wr_strb(wr_mem_strb), .bid(bid), .bvalid(bvalid)
    );

endmodule

// File: hdl/axi_mem_pkg.sv
package axi_mem_pkg;

    // id space, one transfer slot per id and direction
    localparam int id_len = 2;
    localparam int num_ids = 4;

    // one beat is always one full word
    localparam int data_width = 32;
    localparam int strb_width = data_width / 8;

    // byte address into a 256 word memory
    localparam int addr_len = 16;
    localparam int word_addr_len = 8;

    // encoding follows the AXI awburst/arburst field
    typedef enum logic [1:0] {
        FIXED = 2'd0,
        INCR  = 2'd1,
        WRAP  = 2'd2
    } burst_type_e;

    typedef enum logic {
        RESP_IDLE = 1'b0,   // no write response on the bus
        RESP_HOLD = 1'b1    // bvalid up, waiting for bready
    } resp_state_e;

endpackage

// File: hdl/burst_tracker.sv
module burst_tracker (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   start,
    input  logic [axi_mem_pkg::id_len-1:0]         start_id,
    input  logic [axi_mem_pkg::addr_len-1:0]       start_addr,
    input  logic [7:0]                             start_len,
    input  axi_mem_pkg::burst_type_e               start_burst,
    input  logic                                   step,
    input  logic                                   release_slot,
    input  logic [axi_mem_pkg::id_len-1:0]         sel_id,
    output logic [axi_mem_pkg::num_ids-1:0]        busy,
    output logic [axi_mem_pkg::addr_len-1:0]       sel_addr,
    output logic                                   sel_last
);

    logic [axi_mem_pkg::num_ids-1:0]  slot_valid;
    logic [axi_mem_pkg::addr_len-1:0] slot_base [axi_mem_pkg::num_ids];
    logic [7:0]                       slot_len  [axi_mem_pkg::num_ids];
    logic [7:0]                       slot_cnt  [axi_mem_pkg::num_ids];
    axi_mem_pkg::burst_type_e         slot_kind [axi_mem_pkg::num_ids];

    logic [axi_mem_pkg::addr_len-1:0] offset;
    logic [axi_mem_pkg::addr_len-1:0] wrap_mask;
    logic [axi_mem_pkg::addr_len-1:0] linear;

    always_ff @(posedge clk) begin
        if (reset) begin
            slot_valid <= '0;
        end else begin
            if (release_slot)
                slot_valid[sel_id] <= 1'b0;
            if (start)
                slot_valid[start_id] <= 1'b1; // start only ever hits a free slot
        end
    end

    always_ff @(posedge clk) begin
        if (step)
            slot_cnt[sel_id] <= slot_cnt[sel_id] + 8'd1;
        if (start) begin
            slot_base[start_id] <= start_addr;
            slot_len[start_id] <= start_len;
            slot_kind[start_id] <= start_burst;
            slot_cnt[start_id] <= 8'd0;
        end
    end

    // beat offset and wrap window, both in bytes
    always_comb begin
        offset = '0;
        offset[9:0] = {slot_cnt[sel_id], 2'b00};
        wrap_mask = '0;
        wrap_mask[9:0] = {slot_len[sel_id], 2'b00};
        linear = slot_base[sel_id] + offset;
        case (slot_kind[sel_id])
            axi_mem_pkg::FIXED: sel_addr = slot_base[sel_id];
            axi_mem_pkg::INCR:  sel_addr = linear;
            axi_mem_pkg::WRAP:  sel_addr = (linear & wrap_mask) | (slot_base[sel_id] & ~wrap_mask);
            default:            sel_addr = linear;   // reserved code walks like INCR
        endcase
    end

    assign busy = slot_valid;
    assign sel_last = (slot_cnt[sel_id] == slot_len[sel_id]);

endmodule

// File: hdl/read_beat_issuer.sv
module read_beat_issuer (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [axi_mem_pkg::num_ids-1:0]       busy,
    input  logic [axi_mem_pkg::addr_len-1:0]      sel_addr,
    input  logic                                  sel_last,
    input  logic [axi_mem_pkg::data_width-1:0]    mem_data,
    input  logic                                  rready,
    output logic [axi_mem_pkg::id_len-1:0]        sel_id,
    output logic                                  step,
    output logic                                  release_slot,
    output logic [axi_mem_pkg::word_addr_len-1:0] mem_addr,
    output logic [axi_mem_pkg::id_len-1:0]        rid,
    output logic [axi_mem_pkg::data_width-1:0]    rdata,
    output logic                                  rlast,
    output logic                                  rvalid
);

    logic any_busy;
    logic can_load;

    // highest numbered active id gets the data path
    always_comb begin
        any_busy = 1'b0;
        sel_id = '0;
        for (int i = 0; i < axi_mem_pkg::num_ids; i++) begin
            if (busy[i]) begin
                any_busy = 1'b1;
                sel_id = i[axi_mem_pkg::id_len-1:0];
            end
        end
    end

    assign can_load = !rvalid || rready;  // output reg empty or draining
    assign step = any_busy && can_load;
    assign release_slot = step && sel_last;
    assign mem_addr = sel_addr[axi_mem_pkg::word_addr_len+1:2];

    always_ff @(posedge clk) begin
        if (reset)
            rvalid <= 1'b0;
        else if (can_load)
            rvalid <= any_busy;
    end

    // beat payload, held while stalled
    always_ff @(posedge clk) begin
        if (step) begin
            rid <= sel_id;
            rdata <= mem_data;
            rlast <= sel_last;
        end
    end

endmodule

// File: hdl/word_memory.sv
module word_memory (
    input  logic                                  clk,
    input  logic                                  wr_en,
    input  logic [axi_mem_pkg::word_addr_len-1:0] wr_addr,
    input  logic [axi_mem_pkg::data_width-1:0]    wr_data,
    input  logic [axi_mem_pkg::strb_width-1:0]    wr_strb,
    input  logic [axi_mem_pkg::word_addr_len-1:0] rd_addr,
    output logic [axi_mem_pkg::data_width-1:0]    rd_data
);

    logic [axi_mem_pkg::data_width-1:0] mem [2**axi_mem_pkg::word_addr_len];

    // only strobed byte lanes change
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < axi_mem_pkg::strb_width; i++) begin
                if (wr_strb[i])
                    mem[wr_addr][8*i +: 8] <= wr_data[8*i +: 8];
            end
        end
    end

    // async read, the beat register sits in the read issuer
    assign rd_data = mem[rd_addr];

endmodule

// File: hdl/write_beat_sink.sv
module write_beat_sink (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [axi_mem_pkg::data_width-1:0]    wdata,
    input  logic [axi_mem_pkg::strb_width-1:0]    wstrb,
    input  logic                                  wvalid,
    input  logic [axi_mem_pkg::id_len-1:0]        head_id,
    input  logic                                  head_valid,
    input  logic [axi_mem_pkg::addr_len-1:0]      sel_addr,
    input  logic                                  sel_last,
    input  logic                                  bready,
    output logic                                  step,
    output logic                                  release_slot,
    output logic                                  pop,
    output logic                                  mem_wr_en,
    output logic [axi_mem_pkg::word_addr_len-1:0] mem_wr_addr,
    output logic [axi_mem_pkg::data_width-1:0]    mem_wr_data,
    output logic [axi_mem_pkg::strb_width-1:0]    mem_wr_strb,
    output logic [axi_mem_pkg::id_len-1:0]        bid,
    output logic                                  bvalid
);

    axi_mem_pkg::resp_state_e state;
    logic [axi_mem_pkg::num_ids-1:0] done;   // all beats of that id stored
    logic beat;

    // wready is tied high, so a valid beat is a taken beat
    assign beat = wvalid && head_valid;
    assign step = beat;
    assign mem_wr_en = beat;
    assign mem_wr_addr = sel_addr[axi_mem_pkg::word_addr_len+1:2];
    assign mem_wr_data = wdata;
    assign mem_wr_strb = wstrb;

    assign pop = (state == axi_mem_pkg::RESP_IDLE) && head_valid && done[head_id];
    assign release_slot = pop;
    assign bvalid = (state == axi_mem_pkg::RESP_HOLD);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= axi_mem_pkg::RESP_IDLE;
            done <= '0;
        end else begin
            if (pop) begin
                done[head_id] <= 1'b0;
                state <= axi_mem_pkg::RESP_HOLD;
            end else if (state == axi_mem_pkg::RESP_HOLD && bready) begin
                state <= axi_mem_pkg::RESP_IDLE;
            end
            if (beat && sel_last)
                done[head_id] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pop)
            bid <= head_id;
    end

endmodule

// File: hdl/write_id_fifo.sv
module write_id_fifo (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           push,
    input  logic [axi_mem_pkg::id_len-1:0] push_id,
    input  logic                           pop,
    output logic [axi_mem_pkg::id_len-1:0] head_id,
    output logic                           head_valid
);

    // one entry per id, so the queue can never overflow
    logic [axi_mem_pkg::num_ids-1:0] ent_valid;
    logic [axi_mem_pkg::id_len-1:0]  ent_id [axi_mem_pkg::num_ids];

    logic [axi_mem_pkg::num_ids-1:0] shift_valid;
    logic [axi_mem_pkg::id_len-1:0]  shift_id [axi_mem_pkg::num_ids];
    logic [axi_mem_pkg::id_len-1:0]  ins_idx;

    // queue as it looks after this cycle's pop
    always_comb begin
        for (int i = 0; i < axi_mem_pkg::num_ids - 1; i++) begin
            shift_valid[i] = pop ? ent_valid[i+1] : ent_valid[i];
            shift_id[i] = pop ? ent_id[i+1] : ent_id[i];
        end
        shift_valid[axi_mem_pkg::num_ids-1] = pop ? 1'b0 : ent_valid[axi_mem_pkg::num_ids-1];
        shift_id[axi_mem_pkg::num_ids-1] = ent_id[axi_mem_pkg::num_ids-1];

        ins_idx = '0;
        for (int i = axi_mem_pkg::num_ids - 1; i >= 0; i--) begin
            if (!shift_valid[i])
                ins_idx = i[axi_mem_pkg::id_len-1:0]; // lowest free entry wins
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ent_valid <= '0;
        end else begin
            ent_valid <= shift_valid;
            if (push)
                ent_valid[ins_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        ent_id <= shift_id;
        if (push)
            ent_id[ins_idx] <= push_id;
    end

    assign head_id = ent_id[0];
    assign head_valid = ent_valid[0];

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_axi_burst_mem -f axi_burst_mem.f

# the simulation exits nonzero on an assertion stop, the search below decides
out="$(./obj_dir/Vtb_axi_burst_mem 2>&1)" || true
echo "$out"

if grep -qx "STATUS: PASS" <<< "$out"; then
    exit 0
fi
exit 1

// File: test/axi_burst_mem_props.sv
module axi_burst_mem_props (
    input logic                               clk,
    input logic                               reset,
    input logic                               rvalid,
    input logic                               rready,
    input logic                               rlast,
    input logic [axi_mem_pkg::id_len-1:0]     rid,
    input logic [axi_mem_pkg::data_width-1:0] rdata,
    input logic                               bvalid,
    input logic                               bready,
    input logic [axi_mem_pkg::id_len-1:0]     bid,
    input logic                               wvalid,
    input logic                               wready,
    input logic                               wlast,
    input logic                               wr_last,     // write tracker last flag
    input logic                               head_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    // stalled read beat stays put
    r_hold: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rid) && $stable(rdata) && $stable(rlast))
        else $error("read channel changed while rready was low");

    b_hold: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bid))
        else $error("write response changed while bready was low");

    wlast_match: assert property (@(posedge clk) disable iff (reset)
        wvalid && wready |-> wlast == wr_last)
        else $error("wlast does not match the burst length");

    // a beat with no accepted address has no slot to land in
    no_orphan_beat: assert property (@(posedge clk) disable iff (reset)
        wvalid && wready |-> head_valid)
        else $error("write beat accepted with an empty id queue");

endmodule

bind axi_burst_mem axi_burst_mem_props u_axi_burst_mem_props (
    .clk(clk), .reset(reset),
    .rvalid(rvalid), .rready(rready), .rlast(rlast), .rid(rid), .rdata(rdata),
    .bvalid(bvalid), .bready(bready), .bid(bid),
    .wvalid(wvalid), .wready(wready), .wlast(wlast),
    .wr_last(wr_sel_last), .head_valid(head_valid)
);

// File: test/tb_axi_burst_mem.sv
module tb_axi_burst_mem;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int max_cycles = 2000;  // generous bound over all five tests with stalls

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic [axi_mem_pkg::id_len-1:0] awid = '0;
    logic [axi_mem_pkg::addr_len-1:0] awaddr = '0;
    logic [7:0] awlen = '0;
    logic [1:0] awburst = '0;
    logic awvalid = 1'b0;
    logic awready;
    logic [axi_mem_pkg::data_width-1:0] wdata = '0;
    logic [axi_mem_pkg::strb_width-1:0] wstrb = '0;
    logic wlast = 1'b0;
    logic wvalid = 1'b0;
    logic wready;
    logic bready = 1'b0;
    logic [axi_mem_pkg::id_len-1:0] bid;
    logic bvalid;
    logic [axi_mem_pkg::id_len-1:0] arid = '0;
    logic [axi_mem_pkg::addr_len-1:0] araddr = '0;
    logic [7:0] arlen = '0;
    logic [1:0] arburst = '0;
    logic arvalid = 1'b0;
    logic arready;
    logic rready = 1'b0;
    logic [axi_mem_pkg::id_len-1:0] rid;
    logic [axi_mem_pkg::data_width-1:0] rdata;
    logic rlast;
    logic rvalid;

    logic [31:0] ref_mem [256];   // expected memory image by word index
    integer seed = 32'h84d8091a;
    int unsigned cycle_count = 0;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    logic stall_en = 1'b0;        // random rready/bready drops

    axi_burst_mem u_axi_burst_mem (.*);

    always #4 clk = ~clk;

    always @(posedge clk) cycle_count <= cycle_count + 1;

    initial begin
        wait (cycle_count == max_cycles);
        $display("timeout: tests still running after %0d cycles", max_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic pick_ready();
        if (!stall_en)
            return 1'b1;
        return ($random(seed) & 3) != 0;   // low about one cycle in four
    endfunction

    // wrap bursts stay inside their aligned block
    function automatic int beat_addr(input int base, input int len,
                                     input axi_mem_pkg::burst_type_e kind, input int n);
        int block;
        int lower;
        case (kind)
            axi_mem_pkg::FIXED: return base;
            axi_mem_pkg::WRAP: begin
                block = (len + 1) * 4;
                lower = base - (base % block);
                return lower + ((base - lower + n * 4) % block);
            end
            default: return base + n * 4;
        endcase
    endfunction

    task automatic drive_aw(input logic [1:0] id, input int base, input int len,
                            input axi_mem_pkg::burst_type_e kind);
        @(posedge clk);
        awvalid <= 1'b1;
        awid <= id;
        awaddr <= 16'(base);
        awlen <= 8'(len);
        awburst <= kind;
        @(negedge clk);
        while (!awready) @(negedge clk);
        @(posedge clk);
        awvalid <= 1'b0;
    endtask

    task automatic stream_wdata(input int base, input int len,
                                input axi_mem_pkg::burst_type_e kind, input logic [3:0] strb);
        logic [31:0] d;
        logic [31:0] mask;
        logic [7:0] idx;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        for (int n = 0; n <= len; n++) begin
            d = $random(seed);
            @(posedge clk);
            wvalid <= 1'b1;
            wdata <= d;
            wstrb <= strb;
            wlast <= (n == len);
            @(negedge clk);
            while (!wready) @(negedge clk);
            idx = 8'(beat_addr(base, len, kind, n) >> 2);
            ref_mem[idx] = (ref_mem[idx] & ~mask) | (d & mask);
        end
        @(posedge clk);
        wvalid <= 1'b0;
        wlast <= 1'b0;
    endtask

    task automatic await_bresp(input logic [1:0] id);
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            @(posedge clk);
            bready <= pick_ready();
            @(negedge clk);
            taken = bvalid && bready;
        end
        check_value("bid", 32'(bid), 32'(id));
        @(posedge clk);
        bready <= 1'b0;
        @(negedge clk);
        check_value("bvalid after response", 32'(bvalid), 0);   // exactly one response
    endtask

    task automatic request_read(input logic [1:0] id, input int base, input int len,
                                input axi_mem_pkg::burst_type_e kind);
        @(posedge clk);
        arvalid <= 1'b1;
        arid <= id;
        araddr <= 16'(base);
        arlen <= 8'(len);
        arburst <= kind;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        arvalid <= 1'b0;
    endtask

    task automatic collect_rdata(input logic [1:0] id, input int base, input int len,
                                 input axi_mem_pkg::burst_type_e kind);
        int n;
        logic [7:0] idx;
        n = 0;
        while (n <= len) begin
            @(posedge clk);
            rready <= pick_ready();
            @(negedge clk);
            if (rvalid && rready) begin
                idx = 8'(beat_addr(base, len, kind, n) >> 2);
                check_value("rid", 32'(rid), 32'(id));
                check_value("rdata", rdata, ref_mem[idx]);
                check_value("rlast", 32'(rlast), 32'(n == len));
                n++;
            end
        end
        @(posedge clk);
        rready <= 1'b0;
        @(negedge clk);
        check_value("rvalid after last beat", 32'(rvalid), 0);
    endtask

    // second address on a busy id may only go through with the response
    task automatic check_busy_aw(input logic [1:0] id, input int base, input int len,
                                 input axi_mem_pkg::burst_type_e kind);
        logic seen_b;
        seen_b = 1'b0;
        @(posedge clk);
        awvalid <= 1'b1;
        awid <= id;
        awaddr <= 16'(base);
        awlen <= 8'(len);
        awburst <= kind;
        do begin
            @(negedge clk);
            if (bvalid)
                seen_b = 1'b1;
            check_value("awready on busy id", 32'(awready), 32'(seen_b));
        end while (!awready);
        @(posedge clk);
        awvalid <= 1'b0;
    endtask

    task automatic write_burst(input logic [1:0] id, input int base, input int len,
                               input axi_mem_pkg::burst_type_e kind, input logic [3:0] strb);
        drive_aw(id, base, len, kind);
        stream_wdata(base, len, kind, strb);
        await_bresp(id);
    endtask

    task automatic read_burst(input logic [1:0] id, input int base, input int len,
                              input axi_mem_pkg::burst_type_e kind);
        request_read(id, base, len, kind);
        collect_rdata(id, base, len, kind);
    endtask

    task automatic report_test(input string name, input int err0);
        tests++;
        $display("%s: %0d errors", name, errors - err0);
    endtask

    task automatic incr_round_trip();
        int err0;
        err0 = errors;
        write_burst(2'd1, 'h040, 7, axi_mem_pkg::INCR, 4'hf);
        read_burst(2'd2, 'h040, 7, axi_mem_pkg::INCR);
        report_test("incr write/read", err0);
    endtask

    task automatic strobe_merge();
        int err0;
        err0 = errors;
        write_burst(2'd0, 'h100, 3, axi_mem_pkg::INCR, 4'hf);
        write_burst(2'd2, 'h104, 0, axi_mem_pkg::INCR, 4'b0011);
        write_burst(2'd3, 'h108, 0, axi_mem_pkg::INCR, 4'b1000);
        write_burst(2'd1, 'h10c, 0, axi_mem_pkg::FIXED, 4'b0110);
        read_burst(2'd0, 'h100, 3, axi_mem_pkg::INCR);
        report_test("byte strobes", err0);
    endtask

    task automatic fixed_bursts();
        int err0;
        err0 = errors;
        write_burst(2'd0, 'h200, 0, axi_mem_pkg::INCR, 4'hf);
        write_burst(2'd1, 'h200, 3, axi_mem_pkg::FIXED, 4'b0101);
        read_burst(2'd3, 'h200, 2, axi_mem_pkg::FIXED);
        report_test("fixed bursts", err0);
    endtask

    task automatic wrap_bursts();
        int err0;
        err0 = errors;
        write_burst(2'd2, 'h308, 3, axi_mem_pkg::WRAP, 4'hf);
        read_burst(2'd1, 'h304, 3, axi_mem_pkg::WRAP);
        read_burst(2'd0, 'h300, 3, axi_mem_pkg::INCR);   // same block in linear order
        report_test("wrap bursts", err0);
    endtask

    task automatic backpressure_order();
        int err0;
        err0 = errors;
        stall_en = 1'b1;
        drive_aw(2'd0, 'h400, 3, axi_mem_pkg::INCR);
        drive_aw(2'd3, 'h440, 5, axi_mem_pkg::INCR);
        // both bursts complete while the first response still waits for bready
        stream_wdata('h400, 3, axi_mem_pkg::INCR, 4'hf);
        stream_wdata('h440, 5, axi_mem_pkg::INCR, 4'hf);
        await_bresp(2'd0);
        await_bresp(2'd3);
        drive_aw(2'd1, 'h480, 3, axi_mem_pkg::INCR);
        fork
            begin
                stream_wdata('h480, 3, axi_mem_pkg::INCR, 4'hf);
                await_bresp(2'd1);
            end
            check_busy_aw(2'd1, 'h4c0, 1, axi_mem_pkg::INCR);
        join
        stream_wdata('h4c0, 1, axi_mem_pkg::INCR, 4'hf);
        await_bresp(2'd1);
        read_burst(2'd3, 'h440, 5, axi_mem_pkg::INCR);
        read_burst(2'd0, 'h400, 3, axi_mem_pkg::INCR);
        read_burst(2'd1, 'h480, 3, axi_mem_pkg::INCR);
        read_burst(2'd2, 'h4c0, 1, axi_mem_pkg::INCR);
        stall_en = 1'b0;
        report_test("back-pressure and order", err0);
    endtask

    initial begin
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        incr_round_trip();
        strobe_merge();
        fixed_bursts();
        wrap_bursts();
        backpressure_order();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
